// ==== sources.f ====
+incdir+hdl
hdl/ext_bus_pkg.sv
hdl/ext_addr_path.sv
hdl/ext_data_path.sv
hdl/ext_bus_sequencer.sv
hdl/ext_bus_top.sv
tests/ext_bus_asserts.sv
tests/ext_bus_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ext_bus_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tests/ext_bus_tb.sv ====
`timescale 1ns/1ps

`include "ext_bus_defines.svh"

module ext_bus_tb;

	import ext_bus_pkg::*;

	localparam int NUM_TX = 11;
	localparam int MAX_CYCLES = 40 * NUM_TX + 100;
	localparam int EXT_LAT = `EXT_CYCLE_CLKS + 3;

	logic clk, rst_n, cpu_req, cpu_ack, dma_req, dma_ack;
	bus_req_t cpu_req_bus;
	bus_rsp_t cpu_rsp, dma_rsp;
	bus_addr_t dma_addr, exp_addr, last_ext_addr;
	bus_data_t pin_din, exp_wdata, exp_cpu_rdata, exp_dma_rdata;
	ext_pins_t pins;
	logic exp_write, exp_ext, exp_ram, int_active, started;
	logic [15:0] lfsr = 16'd30770;
	int errors = 0, n_pass = 0, n_fail = 0, cycles = 0, err_start;
	string test_name;

	ext_bus_top dut0 (.*);

	// Cartridge model
	assign pin_din = pins.addr[7:0] ^ pins.addr[15:8];

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	a_cpu_rdata: assert property (@(posedge clk) $rose(cpu_ack) && !exp_write
		|-> cpu_rsp.rdata == exp_cpu_rdata) else begin
		errors++;
		$display("Fail %s: expected rdata %h, actual %h", test_name, exp_cpu_rdata, cpu_rsp.rdata);
	end
	a_dma_rdata: assert property (@(posedge clk) $rose(dma_ack)
		|-> dma_rsp.rdata == exp_dma_rdata) else begin
		errors++;
		$display("Fail %s: expected dma rdata %h, actual %h", test_name, exp_dma_rdata, dma_rsp.rdata);
	end
	a_ext_lat: assert property (@(posedge clk) $rose(cpu_req) && !dma_req && exp_ext
		|-> !cpu_ack [*EXT_LAT] ##1 cpu_ack) else begin
		errors++;
		$display("Fail %s: expected ack 6 clocks after req, actual ack %b", test_name, cpu_ack);
	end
	a_int_lat: assert property (@(posedge clk) $rose(cpu_req) && !dma_req && !exp_ext
		|-> !cpu_ack [*3] ##1 cpu_ack) else begin
		errors++;
		$display("Fail %s: expected ack 2 clocks after req, actual ack %b", test_name, cpu_ack);
	end
	a_write: assert property (@(posedge clk) disable iff (!rst_n) $fell(pins.wr_n)
		|-> (!pins.wr_n && pins.doe && pins.addr == exp_addr && pins.dout == exp_wdata &&
		pins.cs_n == !exp_ram) [*`EXT_CYCLE_CLKS] ##1 pins.wr_n) else begin
		errors++;
		$display("Fail %s: expected addr %h dout %h, actual addr %h dout %h",
			test_name, exp_addr, exp_wdata, pins.addr, pins.dout);
	end
	a_read: assert property (@(posedge clk) disable iff (!rst_n) $fell(pins.rd_n)
		|-> (!pins.rd_n && pins.addr == exp_addr && pins.cs_n == !exp_ram)
		[*`EXT_CYCLE_CLKS] ##1 pins.rd_n) else begin
		errors++;
		$display("Fail %s: expected addr %h cs_n %b, actual addr %h cs_n %b",
			test_name, exp_addr, !exp_ram, pins.addr, pins.cs_n);
	end
	a_internal: assert property (@(posedge clk) int_active
		|-> pins.rd_n && pins.wr_n && pins.cs_n && pins.addr == last_ext_addr) else begin
		errors++;
		$display("Fail %s: strobe or address change on an internal access", test_name);
	end
	a_idle_addr: assert property (@(posedge clk) started && !cpu_req && !dma_req && !cpu_ack
		&& !dma_ack |-> pins.addr == last_ext_addr) else begin
		errors++;
		$display("Fail %s: expected idle addr %h, actual %h", test_name, last_ext_addr, pins.addr);
	end
	a_dma_first: assert property (@(posedge clk) dma_req && !dma_ack |-> !cpu_ack) else begin
		errors++;
		$display("Fail %s: cpu_ack came while DMA was still waiting", test_name);
	end
	a_ack_hold: assert property (@(posedge clk) cpu_ack && cpu_req |=> cpu_ack) else begin
		errors++;
		$display("Fail %s: cpu_ack dropped while req was held", test_name);
	end
	a_ack_fall: assert property (@(posedge clk) $fell(cpu_req) && cpu_ack |=> !cpu_ack) else begin
		errors++;
		$display("Fail %s: cpu_ack did not fall one clock after req", test_name);
	end

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	// Galois LFSR, one step per bit taken
	function automatic logic [15:0] get_bits(input int n);
		logic [15:0] v;
		v = '0;
		repeat (n) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	// Own check failures plus those of the bound protocol checker
	function automatic int error_total();
		return errors + dut0.asserts0.fail_count;
	endfunction

	task automatic set_expect(input bus_addr_t addr, input bus_data_t wdata, input logic write);
		exp_addr = addr;
		exp_wdata = wdata;
		exp_write = write;
		exp_ram = (addr >= 16'hA000) && (addr < 16'hFE00);
		exp_ext = (addr < 16'h8000) || exp_ram;
		exp_cpu_rdata = (exp_ext && !write) ? (addr[7:0] ^ addr[15:8]) : 8'hFF;
		cpu_req_bus.addr = addr;
		cpu_req_bus.wdata = wdata;
		cpu_req_bus.write = write;
		if (exp_ext)
			last_ext_addr = addr;
		int_active = !exp_ext;
	endtask

	task automatic cpu_xfer(input bus_addr_t addr, input bus_data_t wdata, input logic write,
			input int hold);
		set_expect(addr, wdata, write);
		cpu_req = 1'b1;
		while (!cpu_ack)
			tick();
		repeat (hold) tick();
		cpu_req = 1'b0;
		while (cpu_ack)
			tick();
		int_active = 1'b0;
		tick();
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		err_start = error_total();
	endtask

	task automatic end_test();
		if (error_total() == err_start) begin
			n_pass++;
			$display("Test %s: ok", test_name);
		end else begin
			n_fail++;
			$display("Test %s: failed", test_name);
		end
	endtask

	initial begin
		logic [15:0] r, d;
		bus_addr_t cpu_addr;
		rst_n = 1'b0;
		cpu_req = 1'b0;
		dma_req = 1'b0;
		dma_addr = '0;
		cpu_req_bus = '0;
		{exp_write, exp_ext, exp_ram, int_active, started} = '0;
		{exp_addr, last_ext_addr, exp_wdata, exp_cpu_rdata, exp_dma_rdata} = '0;
		repeat (5) @(posedge clk);
		#2 rst_n = 1'b1;
		begin_test("reset");
		assert (pins.rd_n && pins.wr_n && pins.cs_n && !pins.doe && !cpu_ack && !dma_ack &&
			pins.addr == 16'h0000) else begin
			errors++;
			$display("Fail reset: expected idle pins at 0000, actual pins %h", pins);
		end
		started = 1'b1;
		end_test();

		begin_test("cpu_write_rom");
		repeat (3) begin
			r = get_bits(15);
			d = get_bits(8);
			cpu_xfer({1'b0, r[14:0]}, d[7:0], 1'b1, 0);
		end
		end_test();

		begin_test("cpu_read_ram");
		repeat (3) begin
			r = get_bits(16);
			cpu_xfer(16'hA000 + (r % 16'h5E00), 8'h00, 1'b0, 0);
		end
		end_test();

		begin_test("internal");
		r = get_bits(13);
		cpu_xfer(16'h8000 + r, 8'h00, 1'b0, 0);
		r = get_bits(9);
		cpu_xfer(16'hFE00 + r, 8'h00, 1'b0, 0);
		end_test();

		begin_test("dma_priority");
		r = get_bits(16);
		dma_addr = 16'hA000 + (r % 16'h5E00);
		exp_dma_rdata = dma_addr[7:0] ^ dma_addr[15:8];
		r = get_bits(15);
		cpu_addr = {1'b0, r[14:0]};
		set_expect(cpu_addr, 8'h00, 1'b0);
		// The DMA read goes out on the pins first
		exp_addr = dma_addr;
		exp_ram = 1'b1;
		cpu_req = 1'b1;
		dma_req = 1'b1;
		while (!dma_ack)
			tick();
		dma_req = 1'b0;
		while (dma_ack)
			tick();
		set_expect(cpu_addr, 8'h00, 1'b0);
		while (!cpu_ack)
			tick();
		cpu_req = 1'b0;
		while (cpu_ack)
			tick();
		tick();
		end_test();

		begin_test("hold_and_idle");
		r = get_bits(15);
		cpu_xfer({1'b0, r[14:0]}, 8'h00, 1'b0, 3);
		repeat (4) tick();
		end_test();

		$display("Tests: %0d passed, %0d failed, %0d errors", n_pass, n_fail, error_total());
		if (error_total() == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// ==== tests/ext_bus_asserts.sv ====
`timescale 1ns/1ps

module ext_bus_asserts (
		input logic                   clk,
		input logic                   rst_n,
		input logic                   cpu_req,
		input logic                   cpu_ack,
		input logic                   dma_req,
		input logic                   dma_ack,
		input ext_bus_pkg::ext_pins_t pins
	);

	import ext_bus_pkg::*;

	int unsigned fail_count = 0;

	// Acks hold while req stays up and fall one clock after req drops
	a_cpu_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ack && cpu_req |=> cpu_ack) else begin
		fail_count++;
		$error("cpu_ack dropped early");
	end
	a_dma_hold: assert property (@(posedge clk) disable iff (!rst_n)
		dma_ack && dma_req |=> dma_ack) else begin
		fail_count++;
		$error("dma_ack dropped early");
	end
	a_cpu_rel: assert property (@(posedge clk) disable iff (!rst_n)
		cpu_ack && !cpu_req |=> !cpu_ack) else begin
		fail_count++;
		$error("cpu_ack stuck after release");
	end
	a_dma_rel: assert property (@(posedge clk) disable iff (!rst_n)
		dma_ack && !dma_req |=> !dma_ack) else begin
		fail_count++;
		$error("dma_ack stuck after release");
	end

	a_one_ack: assert property (@(posedge clk) disable iff (!rst_n)
		!(cpu_ack && dma_ack)) else begin
		fail_count++;
		$error("both acks high");
	end
	// One strobe at a time, and never while an ack is up
	a_strobes: assert property (@(posedge clk) disable iff (!rst_n)
		(!pins.rd_n || !pins.wr_n) |-> (pins.rd_n ^ pins.wr_n) && !cpu_ack && !dma_ack)
		else begin
		fail_count++;
		$error("strobes overlap or a strobe is low during ack");
	end
	// Data is driven exactly during the write strobe
	a_doe: assert property (@(posedge clk) disable iff (!rst_n)
		pins.doe == !pins.wr_n) else begin
		fail_count++;
		$error("doe out of step with wr_n");
	end

endmodule

bind ext_bus_top ext_bus_asserts asserts0 (.*);

// ==== hdl/ext_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ext_bus_top (
		input  logic                   clk,
		input  logic                   rst_n,
		input  logic                   cpu_req,
		input  ext_bus_pkg::bus_req_t  cpu_req_bus,
		output logic                   cpu_ack,
		output ext_bus_pkg::bus_rsp_t  cpu_rsp,
		input  logic                   dma_req,
		input  ext_bus_pkg::bus_addr_t dma_addr,
		output logic                   dma_ack,
		output ext_bus_pkg::bus_rsp_t  dma_rsp,
		output ext_bus_pkg::ext_pins_t pins,
		input  ext_bus_pkg::bus_data_t pin_din
	);

	import ext_bus_pkg::*;

	logic       sel_dma;
	logic       capture_addr;
	logic       drive_en;
	logic       capture_data;
	addr_info_t info;
	bus_addr_t  pin_addr;
	bus_data_t  dout;
	logic       doe;
	bus_data_t  rdata;

	ext_addr_path addr_path0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_addr     (cpu_req_bus.addr),
		.dma_addr     (dma_addr),
		.sel_dma      (sel_dma),
		.capture_addr (capture_addr),
		.info         (info),
		.pin_addr     (pin_addr)
	);

	// DMA only reads, so write data always comes from the CPU
	ext_data_path data_path0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.wdata        (cpu_req_bus.wdata),
		.pin_din      (pin_din),
		.drive_en     (drive_en),
		.capture_data (capture_data),
		.dout         (dout),
		.doe          (doe),
		.rdata        (rdata)
	);

	ext_bus_sequencer seq0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_req      (cpu_req),
		.cpu_req_bus  (cpu_req_bus),
		.dma_req      (dma_req),
		.info         (info),
		.pin_addr     (pin_addr),
		.dout         (dout),
		.doe          (doe),
		.rdata        (rdata),
		.sel_dma      (sel_dma),
		.capture_addr (capture_addr),
		.drive_en     (drive_en),
		.capture_data (capture_data),
		.cpu_ack      (cpu_ack),
		.cpu_rsp      (cpu_rsp),
		.dma_ack      (dma_ack),
		.dma_rsp      (dma_rsp),
		.pins         (pins)
	);

endmodule

`default_nettype wire

// ==== hdl/ext_bus_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_defines.svh"

module ext_bus_sequencer (
		input  logic                    clk,
		input  logic                    rst_n,
		input  logic                    cpu_req,
		input  ext_bus_pkg::bus_req_t   cpu_req_bus,
		input  logic                    dma_req,
		input  ext_bus_pkg::addr_info_t info,
		input  ext_bus_pkg::bus_addr_t  pin_addr,
		input  ext_bus_pkg::bus_data_t  dout,
		input  logic                    doe,
		input  ext_bus_pkg::bus_data_t  rdata,
		output logic                    sel_dma,
		output logic                    capture_addr,
		output logic                    drive_en,
		output logic                    capture_data,
		output logic                    cpu_ack,
		output ext_bus_pkg::bus_rsp_t   cpu_rsp,
		output logic                    dma_ack,
		output ext_bus_pkg::bus_rsp_t   dma_rsp,
		output ext_bus_pkg::ext_pins_t  pins
	);

	import ext_bus_pkg::*;

	localparam int CNT_W = (`EXT_CYCLE_CLKS > 1) ? $clog2(`EXT_CYCLE_CLKS) : 1;
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`EXT_CYCLE_CLKS - 1);

	seq_state_t       state;
	logic [CNT_W-1:0] cnt;
	logic             grant_dma;
	logic             ext_q;
	logic             ram_q;
	logic             write_q;
	logic             any_req;
	logic             gnt_req;
	logic             last_strobe;
	bus_data_t        rsp_byte;

	assign any_req     = cpu_req || dma_req;
	assign gnt_req     = grant_dma ? dma_req : cpu_req;
	assign last_strobe = (state == STROBE) && (cnt == LAST_CNT);

	// In IDLE the mux follows the arbiter so the decode is valid on the granting edge
	assign sel_dma      = (state == IDLE) ? dma_req : grant_dma;
	assign capture_addr = (state == IDLE) && any_req;
	assign capture_data = last_strobe && !write_q;
	assign drive_en     = ext_q && write_q &&
		((state == SETUP) || ((state == STROBE) && !last_strobe));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= IDLE;
			cnt       <= '0;
			grant_dma <= 1'b0;
			ext_q     <= 1'b0;
			ram_q     <= 1'b0;
			write_q   <= 1'b0;
			cpu_ack   <= 1'b0;
			dma_ack   <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					// DMA wins a tie
					if (any_req) begin
						grant_dma <= dma_req;
						ext_q     <= info.external;
						ram_q     <= info.ram_cs;
						write_q   <= !dma_req && cpu_req_bus.write;
						state     <= SETUP;
					end
				end
				SETUP: begin
					cnt   <= '0;
					state <= ext_q ? STROBE : DONE;
				end
				STROBE: begin
					cnt <= cnt + 1'b1;
					if (last_strobe) begin
						state <= DONE;
					end
				end
				DONE: begin
					if (grant_dma) begin
						dma_ack <= 1'b1;
					end else begin
						cpu_ack <= 1'b1;
					end
					state <= RELEASE;
				end
				RELEASE: begin
					// Grant is kept until the owner drops req
					if (!gnt_req) begin
						cpu_ack <= 1'b0;
						dma_ack <= 1'b0;
						state   <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Internal accesses read as open bus
	assign rsp_byte = (ext_q && !write_q) ? rdata : `EXT_OPEN_BUS;

	assign cpu_rsp.rdata = rsp_byte;
	assign dma_rsp.rdata = rsp_byte;

	always_comb begin
		pins.addr = pin_addr;
		pins.dout = dout;
		pins.doe  = doe;
		pins.rd_n = !((state == STROBE) && !write_q);
		pins.wr_n = !((state == STROBE) && write_q);
		pins.cs_n = !(ram_q && (state inside {SETUP, STROBE, DONE}));
	end

endmodule

`default_nettype wire

// ==== hdl/ext_data_path.sv ====
`timescale 1ns/1ps
`default_nettype none

module ext_data_path (
		input  logic                   clk,
		input  logic                   rst_n,
		input  ext_bus_pkg::bus_data_t wdata,
		input  ext_bus_pkg::bus_data_t pin_din,
		input  logic                   drive_en,
		input  logic                   capture_data,
		output ext_bus_pkg::bus_data_t dout,
		output logic                   doe,
		output ext_bus_pkg::bus_data_t rdata
	);

	// drive_en leads the write strobe by one clock
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			doe <= 1'b0;
		end else begin
			doe <= drive_en;
		end
	end

	always_ff @(posedge clk) begin
		if (drive_en) begin
			dout <= wdata;
		end
	end

	// Held until the next read, stable through ack
	always_ff @(posedge clk) begin
		if (capture_data) begin
			rdata <= pin_din;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ext_addr_path.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "ext_bus_defines.svh"

module ext_addr_path (
		input  logic                    clk,
		input  logic                    rst_n,
		input  ext_bus_pkg::bus_addr_t  cpu_addr,
		input  ext_bus_pkg::bus_addr_t  dma_addr,
		input  logic                    sel_dma,
		input  logic                    capture_addr,
		output ext_bus_pkg::addr_info_t info,
		output ext_bus_pkg::bus_addr_t  pin_addr
	);

	import ext_bus_pkg::*;

	bus_addr_t src_addr;
	logic      in_rom;
	logic      in_ram;

	// DMA owns the address mux while it holds the grant
	assign src_addr = sel_dma ? dma_addr : cpu_addr;

	// ROM below 8000, cartridge and work RAM from A000 up to the high page
	assign in_rom = src_addr < `EXT_VRAM_LO;
	assign in_ram = (src_addr >= `EXT_RAM_LO) && (src_addr < `EXT_HIGH_LO);

	always_comb begin
		info.external = in_rom || in_ram;
		info.ram_cs   = in_ram;
	end

	// Pin latch only opens for external cycles, so idle pins keep the last address
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pin_addr <= '0;
		end else if (capture_addr && info.external) begin
			pin_addr <= src_addr;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ext_bus_pkg.sv ====
`include "ext_bus_defines.svh"

package ext_bus_pkg;

	typedef logic [`EXT_ADDR_W-1:0] bus_addr_t;
	typedef logic [`EXT_DATA_W-1:0] bus_data_t;

	// Request from a bus master, held stable while req is high
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t wdata;
		logic      write;
	} bus_req_t;

	typedef struct packed {
		bus_data_t rdata;
	} bus_rsp_t;

	// Region decode of the selected address
	typedef struct packed {
		logic external;
		logic ram_cs;
	} addr_info_t;

	// Cartridge side, strobes and select active low
	typedef struct packed {
		bus_addr_t addr;
		bus_data_t dout;
		logic      doe;
		logic      rd_n;
		logic      wr_n;
		logic      cs_n;
	} ext_pins_t;

	typedef enum logic [2:0] {
		IDLE,
		SETUP,
		STROBE,
		DONE,
		RELEASE
	} seq_state_t;

endpackage

// ==== hdl/ext_bus_defines.svh ====
`ifndef EXT_BUS_DEFINES_SVH
`define EXT_BUS_DEFINES_SVH

// Bus widths
`define EXT_ADDR_W 16
`define EXT_DATA_W 8

// Clocks that rd_n or wr_n stay low in one external cycle
`define EXT_CYCLE_CLKS 4

// Region bounds, each the first address of its region
`define EXT_VRAM_LO 16'h8000
`define EXT_RAM_LO  16'hA000
`define EXT_HIGH_LO 16'hFE00

// Read data returned for internal addresses
`define EXT_OPEN_BUS 8'hFF

`endif
